/* common/filterPkg.sv */
package filterPkg;

  // number of filter slots in the bank
  localparam int numFilts = 10;

  localparam int stateWidth = 27;

  // increment and decay share one width
  // decay is a fraction scaled by 2**stateWidth
  localparam int constWidth = 27;

  // full state times decay product
  localparam int decayWidth = stateWidth + constWidth;

  typedef logic [stateWidth-1:0] filterState_t;

  typedef logic [constWidth-1:0] filterConst_t;

  // saturation ceiling
  localparam filterState_t stateMax = '1;

endpackage

/* common/linkPkg.sv */
package linkPkg;

  // spike count carried with each tag
  localparam int ctWidth = 9;

  // wide enough to name every filter slot
  localparam int tagWidth = 4;

  typedef logic [tagWidth-1:0] filtIdx_t;

  typedef logic [ctWidth-1:0] spikeCt_t;

endpackage

/* common/tagIf.sv */
`timescale 1ns/10ps

interface tagIf;

  logic              req;
  logic              ack;
  linkPkg::filtIdx_t tag;
  linkPkg::spikeCt_t ct;

  // four-phase, data held while req is high
  modport sender (
    output req, tag, ct,
    input  ack
  );

  modport receiver (
    input  req, tag, ct,
    output ack
  );

endinterface

/* common/reportIf.sv */
`timescale 1ns/10ps

interface reportIf;

  logic                   req;
  logic                   ack;
  linkPkg::filtIdx_t      idx;
  filterPkg::filterState_t state;

  // one filter report per handshake
  modport sender (
    output req, idx, state,
    input  ack
  );

  modport receiver (
    input  req, idx, state,
    output ack
  );

endinterface

/* src/tagReceiver.sv */
`timescale 1ns/10ps

module tagReceiver (
  input  logic              clk,
  input  logic              rstN,
  input  logic              inReq,
  input  linkPkg::filtIdx_t inTag,
  input  linkPkg::spikeCt_t inCt,
  output logic              inAck,
  tagIf.sender              tags
);
  import linkPkg::*;

  filtIdx_t tagHold;
  spikeCt_t ctHold;
  logic     idle;

  // no message in flight on either side
  assign idle = !tags.req && !inAck;

  assign tags.tag = tagHold;
  assign tags.ct  = ctHold;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      tags.req <= 1'b0;
      inAck    <= 1'b0;
    end else if (idle) begin
      if (inReq) begin
        tags.req <= 1'b1;
      end
    end else if (tags.req) begin
      // bank has consumed it, now answer outside
      if (tags.ack) begin
        tags.req <= 1'b0;
        inAck    <= 1'b1;
      end
    end else if (!tags.ack && !inReq) begin
      inAck <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (idle && inReq) begin
      tagHold <= inTag;
      ctHold  <= inCt;
    end
  end

  // sender must hold the tag until we answer
  assert property (@(posedge clk) disable iff (!rstN)
    (inReq && !inAck) |=> (!inReq || $stable(inTag)))
    else $error("inTag changed while inReq was waiting for inAck");

endmodule

/* filterBank/filterStateBank.sv */
`timescale 1ns/10ps

module filterStateBank (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    updatePulse,
  input  filterPkg::filterConst_t incrementConstant,
  input  filterPkg::filterConst_t decayConstant,
  input  linkPkg::filtIdx_t       filtsUsed,
  tagIf.receiver                  tags,
  reportIf.sender                 reports
);
  import filterPkg::*;
  import linkPkg::*;

  filterState_t states [numFilts];

  logic         sweeping;
  logic         waitAckLow;
  logic         issue;
  filtIdx_t     sweepIdx;
  filtIdx_t     activeCt;
  filtIdx_t     lastIdx;

  logic         tagHit;
  filterState_t tagState;
  logic [constWidth+ctWidth-1:0] incProd;
  logic [constWidth+ctWidth:0]   accSum;
  filterState_t accState;

  logic [decayWidth-1:0] decayProd;
  filterState_t          decayState;

  // filtsUsed beyond the bank size is clamped
  assign activeCt = (filtsUsed > filtIdx_t'(numFilts)) ? filtIdx_t'(numFilts) : filtsUsed;
  assign lastIdx  = activeCt - filtIdx_t'(1);
  assign tagHit   = tags.tag < activeCt;

  always_comb begin
    tagState = '0;
    if (tagHit) begin
      tagState = states[tags.tag];
    end
  end

  // accumulate with saturation
  assign incProd  = incrementConstant * tags.ct;
  assign accSum   = tagState + incProd;
  assign accState = (accSum > stateMax) ? stateMax : accSum[stateWidth-1:0];

  // keep the upper half of state * fraction
  assign decayProd  = states[sweepIdx] * decayConstant;
  assign decayState = decayProd[decayWidth-1 -: stateWidth];

  // ready to put the next report on the link
  assign issue = sweeping && !reports.req && !waitAckLow;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < numFilts; i++) begin
        states[i] <= '0;
      end
      tags.ack    <= 1'b0;
      reports.req <= 1'b0;
      sweeping    <= 1'b0;
      waitAckLow  <= 1'b0;
      sweepIdx    <= '0;
    end else begin
      // tag intake only while idle so a sweep stalls the input link
      if (!sweeping && tags.req && !tags.ack) begin
        tags.ack <= 1'b1;
        if (tagHit) begin
          states[tags.tag] <= accState;
        end
      end else if (tags.ack && !tags.req) begin
        tags.ack <= 1'b0;
      end

      if (!sweeping) begin
        if (updatePulse && activeCt != '0) begin
          sweeping <= 1'b1;
          sweepIdx <= '0;
        end
      end else if (issue) begin
        reports.req <= 1'b1;
      end else if (reports.req) begin
        // reported value is out so decay it in place
        if (reports.ack) begin
          states[sweepIdx] <= decayState;
          reports.req      <= 1'b0;
          waitAckLow       <= 1'b1;
        end
      end else if (waitAckLow && !reports.ack) begin
        waitAckLow <= 1'b0;
        if (sweepIdx >= lastIdx) begin
          sweeping <= 1'b0;
        end else begin
          sweepIdx <= sweepIdx + filtIdx_t'(1);
        end
      end
    end
  end

  // pre-decay value travels with the request
  always_ff @(posedge clk) begin
    if (issue) begin
      reports.idx   <= sweepIdx;
      reports.state <= states[sweepIdx];
    end
  end

  // pulses are not queued
  assert property (@(posedge clk) disable iff (!rstN)
    sweeping |-> !updatePulse)
    else $error("updatePulse arrived during a sweep and was dropped");

  assert property (@(posedge clk) disable iff (!rstN)
    (!reports.req && reports.ack) |=> !reports.req)
    else $error("report req raised before the previous ack fell");

endmodule

/* src/stateReporter.sv */
`timescale 1ns/10ps

module stateReporter (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    outAck,
  output logic                    outReq,
  output linkPkg::filtIdx_t       outIdx,
  output filterPkg::filterState_t outState,
  reportIf.receiver               reports
);
  import filterPkg::*;
  import linkPkg::*;

  filtIdx_t     idxHold;
  filterState_t stateHold;
  logic         take;

  // report pending and no ack on either side
  assign take = reports.req && !reports.ack && !outAck;

  assign outIdx   = idxHold;
  assign outState = stateHold;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outReq      <= 1'b0;
      reports.ack <= 1'b0;
    end else if (!outReq && !reports.ack) begin
      if (take) begin
        outReq <= 1'b1;
      end
    end else if (outReq) begin
      // off-chip side took it so release the bank
      if (outAck) begin
        outReq      <= 1'b0;
        reports.ack <= 1'b1;
      end
    end else if (!reports.req && !outAck) begin
      reports.ack <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      idxHold   <= reports.idx;
      stateHold <= reports.state;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    (outReq && $past(outReq)) |-> $stable(outState))
    else $error("outState changed while outReq was high");

endmodule

/* src/spikeFilterTop.sv */
`timescale 1ns/10ps

module spikeFilterTop (
  input  logic                    clk,
  input  logic                    rstN,
  // tag input link
  input  logic                    inReq,
  output logic                    inAck,
  input  linkPkg::filtIdx_t       inTag,
  input  linkPkg::spikeCt_t       inCt,
  // report output link
  output logic                    outReq,
  input  logic                    outAck,
  output linkPkg::filtIdx_t       outIdx,
  output filterPkg::filterState_t outState,
  // static config
  input  filterPkg::filterConst_t incrementConstant,
  input  filterPkg::filterConst_t decayConstant,
  input  linkPkg::filtIdx_t       filtsUsed,
  input  logic                    updatePulse
);

  tagIf    tagLink ();
  reportIf reportLink ();

  tagReceiver tagRx (
    .clk   (clk),
    .rstN  (rstN),
    .inReq (inReq),
    .inTag (inTag),
    .inCt  (inCt),
    .inAck (inAck),
    .tags  (tagLink.sender)
  );

  filterStateBank stateBank (
    .clk               (clk),
    .rstN              (rstN),
    .updatePulse       (updatePulse),
    .incrementConstant (incrementConstant),
    .decayConstant     (decayConstant),
    .filtsUsed         (filtsUsed),
    .tags              (tagLink.receiver),
    .reports           (reportLink.sender)
  );

  stateReporter reporter (
    .clk      (clk),
    .rstN     (rstN),
    .outAck   (outAck),
    .outReq   (outReq),
    .outIdx   (outIdx),
    .outState (outState),
    .reports  (reportLink.receiver)
  );

endmodule

/* test/spikeFilterTb.sv */
`timescale 1ns/10ps

module spikeFilterTb;
  import filterPkg::*;
  import linkPkg::*;

  localparam int numSteps = 30;
  localparam int reportLimit = 100;

  localparam logic [1:0] kindTag = 2'd0;
  localparam logic [1:0] kindSweep = 2'd1;
  // sweep with slow outAck and a tag sent in the middle of it
  localparam logic [1:0] kindStallSweep = 2'd2;

  typedef struct packed {
    logic [1:0]   kind;
    filtIdx_t     tag;
    spikeCt_t     ct;
    filterConst_t inc;
    filterConst_t dec;
    filtIdx_t     fu;
  } step_t;

  logic         clk;
  logic         rstN;
  logic         inReq;
  logic         inAck;
  filtIdx_t     inTag;
  spikeCt_t     inCt;
  logic         outReq;
  logic         outAck;
  filtIdx_t     outIdx;
  filterState_t outState;
  filterConst_t incrementConstant;
  filterConst_t decayConstant;
  filtIdx_t     filtsUsed;
  logic         updatePulse;

  step_t        steps [numSteps];
  filterState_t model [numFilts];
  filtIdx_t     expIdx [numFilts];
  filterState_t expState [numFilts];
  filtIdx_t     gotIdx [$];
  filterState_t gotState [$];

  integer seed = 32'h47e8;
  int     ackDelay;
  int     reportsSeen = 0;
  logic   slowAck = 1'b0;
  time    lastAckFall = 0;
  time    tagAckTime = 0;
  int     valueErrors = 0;
  int     protocolErrors = 0;

  spikeFilterTop spikeFilterTop_inst (
    .clk               (clk),
    .rstN              (rstN),
    .inReq             (inReq),
    .inAck             (inAck),
    .inTag             (inTag),
    .inCt              (inCt),
    .outReq            (outReq),
    .outAck            (outAck),
    .outIdx            (outIdx),
    .outState          (outState),
    .incrementConstant (incrementConstant),
    .decayConstant     (decayConstant),
    .filtsUsed         (filtsUsed),
    .updatePulse       (updatePulse)
  );

  always begin
    clk = 1'b0;
    #10;
    clk = 1'b1;
    #10;
  end

  // saturating accumulate, worked out in 64 bits
  function automatic filterState_t satAdd(input filterState_t cur, input filterConst_t inc,
                                          input spikeCt_t ct);
    logic [63:0] sum;
    logic [63:0] full;
    full = (64'd1 << stateWidth) - 64'd1;
    sum = {37'd0, cur} + {37'd0, inc} * {55'd0, ct};
    satAdd = (sum > full) ? full[stateWidth-1:0] : sum[stateWidth-1:0];
  endfunction

  // state times fraction over 2**stateWidth
  function automatic filterState_t decayed(input filterState_t cur, input filterConst_t dec);
    logic [63:0] prod;
    prod = {37'd0, cur} * {37'd0, dec};
    decayed = prod[stateWidth +: stateWidth];
  endfunction

  function automatic int activeCount(input filtIdx_t fu);
    activeCount = (fu > numFilts) ? numFilts : int'(fu);
  endfunction

  task automatic putStep(input int i, input logic [1:0] k, input filtIdx_t t, input spikeCt_t c,
                         input filterConst_t inc, input filterConst_t dec, input filtIdx_t fu);
    step_t s;
    s.kind = k;
    s.tag = t;
    s.ct = c;
    s.inc = inc;
    s.dec = dec;
    s.fu = fu;
    steps[i] = s;
  endtask

  task automatic applyTag(input filtIdx_t t, input spikeCt_t c, input filterConst_t inc,
                          input filtIdx_t fu);
    if (t < activeCount(fu)) begin
      model[t] = satAdd(model[t], inc, c);
    end
  endtask

  // expected reports first, then the model decays
  task automatic predictSweep(input filtIdx_t fu, input filterConst_t dec, output int count);
    count = activeCount(fu);
    for (int i = 0; i < count; i++) begin
      expIdx[i] = filtIdx_t'(i);
      expState[i] = model[i];
      model[i] = decayed(model[i], dec);
    end
  endtask

  task automatic sendTag(input filtIdx_t t, input spikeCt_t c);
    @(posedge clk);
    #2;
    inTag = t;
    inCt = c;
    inReq = 1'b1;
    do begin
      @(posedge clk);
      #2;
    end while (!inAck);
    tagAckTime = $time;
    inReq = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (inAck);
  endtask

  task automatic checkReport(input filtIdx_t wantIdx, input filterState_t wantState);
    filtIdx_t     idx;
    filterState_t st;
    idx = gotIdx.pop_front();
    st = gotState.pop_front();
    if (idx !== wantIdx) begin
      $display("[FAIL] outIdx expected %h got %h", wantIdx, idx);
      valueErrors++;
    end
    if (st !== wantState) begin
      $display("[FAIL] outState expected %h got %h (outIdx %h)", wantState, st, idx);
      valueErrors++;
    end
  endtask

  task automatic collectReports(input int expCount);
    int   waited;
    int   k;
    logic lost;
    k = 0;
    lost = 1'b0;
    while (k < expCount && !lost) begin
      waited = 0;
      while (gotIdx.size() == 0 && waited < reportLimit) begin
        @(negedge clk);
        waited++;
      end
      if (gotIdx.size() == 0) begin
        $display("report %0d of %0d never arrived", k, expCount);
        protocolErrors++;
        lost = 1'b1;
      end else begin
        checkReport(expIdx[k], expState[k]);
        k++;
      end
    end
    // wait out the last handshake
    waited = 0;
    while ((outReq || outAck) && waited < reportLimit) begin
      @(negedge clk);
      waited++;
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic runSweep(input step_t s);
    int expCount;
    int seenBefore;
    if (gotIdx.size() != 0) begin
      $display("%0d report(s) arrived that no sweep asked for", gotIdx.size());
      protocolErrors++;
      gotIdx.delete();
      gotState.delete();
    end
    predictSweep(s.fu, s.dec, expCount);
    slowAck = (s.kind == kindStallSweep);
    seenBefore = reportsSeen;
    updatePulse = 1'b1;
    @(posedge clk);
    #2;
    updatePulse = 1'b0;
    if (s.kind == kindStallSweep) begin
      fork
        collectReports(expCount);
        begin
          while (reportsSeen == seenBefore) @(negedge clk);
          sendTag(s.tag, s.ct);
        end
      join
      if (tagAckTime <= lastAckFall) begin
        $display("tag sent during the sweep was acked at %0t, before the sweep ended at %0t",
                 tagAckTime, lastAckFall);
        protocolErrors++;
      end
      applyTag(s.tag, s.ct, s.inc, s.fu);
    end else begin
      collectReports(expCount);
    end
    slowAck = 1'b0;
  endtask

  // output side responder
  always begin
    @(posedge clk);
    #2;
    if (rstN && outReq && !outAck) begin
      gotIdx.push_back(outIdx);
      gotState.push_back(outState);
      reportsSeen++;
      ackDelay = $unsigned($random(seed)) % 8;
      if (slowAck) begin
        ackDelay = ackDelay + 12;
      end
      repeat (ackDelay) begin
        @(posedge clk);
        #2;
      end
      outAck = 1'b1;
      do begin
        @(posedge clk);
        #2;
      end while (outReq);
      outAck = 1'b0;
      lastAckFall = $time;
    end
  end

  initial begin
    repeat (numSteps * 400) @(posedge clk);
    $display("watchdog expired before the stimulus table was done");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    step_t cur;
    rstN = 1'b0;
    inReq = 1'b0;
    inTag = '0;
    inCt = '0;
    outAck = 1'b0;
    incrementConstant = '0;
    decayConstant = '0;
    filtsUsed = '0;
    updatePulse = 1'b0;
    for (int i = 0; i < numFilts; i++) begin
      model[i] = '0;
    end

    // no filters active, tags must still complete
    putStep(0, kindTag, 4'd0, 9'd5, 27'd1, 27'd0, 4'd0);
    putStep(1, kindTag, 4'd3, 9'd7, 27'd1, 27'd0, 4'd0);
    putStep(2, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd0);
    // count mode
    putStep(3, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd4);
    putStep(4, kindTag, 4'd0, 9'd1, 27'd1, 27'd0, 4'd4);
    putStep(5, kindTag, 4'd1, 9'd511, 27'd1, 27'd0, 4'd4);
    putStep(6, kindTag, 4'd2, 9'd1, 27'd1, 27'd0, 4'd4);
    putStep(7, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd4);
    putStep(8, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd4);
    // tags beyond filtsUsed are dropped
    putStep(9, kindTag, 4'd4, 9'd100, 27'd1, 27'd0, 4'd4);
    putStep(10, kindTag, 4'd9, 9'd50, 27'd1, 27'd0, 4'd4);
    putStep(11, kindTag, 4'd15, 9'd3, 27'd1, 27'd0, 4'd4);
    putStep(12, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd4);
    putStep(13, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd10);
    // decay mode, just under one half
    putStep(14, kindTag, 4'd0, 9'd300, 27'd2560, 27'd67041788, 4'd6);
    putStep(15, kindTag, 4'd5, 9'd17, 27'd2560, 27'd67041788, 4'd6);
    putStep(16, kindTag, 4'd2, 9'd511, 27'd2560, 27'd67041788, 4'd6);
    putStep(17, kindSweep, 4'd0, 9'd0, 27'd2560, 27'd67041788, 4'd6);
    putStep(18, kindTag, 4'd0, 9'd40, 27'd2560, 27'd67041788, 4'd6);
    putStep(19, kindSweep, 4'd0, 9'd0, 27'd2560, 27'd67041788, 4'd6);
    putStep(20, kindSweep, 4'd0, 9'd0, 27'd2560, 27'd67041788, 4'd6);
    // saturation
    putStep(21, kindTag, 4'd1, 9'd1, 27'h5000000, 27'd0, 4'd6);
    putStep(22, kindTag, 4'd1, 9'd1, 27'h5000000, 27'd0, 4'd6);
    putStep(23, kindTag, 4'd3, 9'd511, 27'h7ffffff, 27'd0, 4'd6);
    putStep(24, kindTag, 4'd3, 9'd2, 27'h7ffffff, 27'd0, 4'd6);
    putStep(25, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd6);
    putStep(26, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd6);
    // tag held off by a stalled sweep
    putStep(27, kindTag, 4'd2, 9'd9, 27'd1, 27'd0, 4'd3);
    putStep(28, kindStallSweep, 4'd2, 9'd20, 27'd1, 27'd0, 4'd3);
    putStep(29, kindSweep, 4'd0, 9'd0, 27'd1, 27'd0, 4'd3);

    repeat (8) @(posedge clk);
    #2;
    rstN = 1'b1;

    for (int i = 0; i < numSteps; i++) begin
      cur = steps[i];
      @(posedge clk);
      #2;
      incrementConstant = cur.inc;
      decayConstant = cur.dec;
      filtsUsed = cur.fu;
      if (cur.kind == kindTag) begin
        sendTag(cur.tag, cur.ct);
        applyTag(cur.tag, cur.ct, cur.inc, cur.fu);
      end else begin
        runSweep(cur);
      end
    end

    repeat (20) @(posedge clk);
    if (gotIdx.size() != 0) begin
      $display("%0d report(s) left over after the last sweep", gotIdx.size());
      protocolErrors++;
    end

    $display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
    if (valueErrors + protocolErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
common/filterPkg.sv
common/linkPkg.sv
common/tagIf.sv
common/reportIf.sv
src/tagReceiver.sv
filterBank/filterStateBank.sv
src/stateReporter.sv
src/spikeFilterTop.sv
test/spikeFilterTb.sv

/* Bender.yml */
package:
  name: spikeFilter

sources:
  # packages and interfaces first
  - common/filterPkg.sv
  - common/linkPkg.sv
  - common/tagIf.sv
  - common/reportIf.sv
  # design blocks
  - src/tagReceiver.sv
  - filterBank/filterStateBank.sv
  - src/stateReporter.sv
  - src/spikeFilterTop.sv
  # testbench
  - target: simulation
    files:
      - test/spikeFilterTb.sv
